// File: Bender.yml
package:
  name: cache_sys

sources:
  - cache_sys_pkg.sv
  - ram_sp_be.sv
  - cache_store.sv
  - cache_ctrl.sv
  - cache_sys_top.sv
  - target: test
    files:
      - cache_sys_properties.sv
      - cache_sys_tb.sv

// File: cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
   parameter int NLINES_W = 4,
   localparam int tag_w = cache_sys_pkg::addr_w - cache_sys_pkg::word_offset_w - NLINES_W
) (
   input  logic                       clk,
   input  logic                       rst_n,

   input  logic                       req,
   input  cache_sys_pkg::cpu_req_t    cpu_req,
   output cache_sys_pkg::word_t       rdata,
   output logic                       ack,

   output logic                       mem_valid,
   output cache_sys_pkg::mem_req_t    mem_req,
   input  cache_sys_pkg::line_t       mem_rdata,
   input  logic                       mem_ack,

   output logic [NLINES_W-1:0]        store_index,
   output logic                       store_rd_en,
   input  logic [tag_w-1:0]           rd_tag,
   input  logic                       rd_valid,
   input  cache_sys_pkg::line_t       rd_line,

   output logic                       store_wr_en,
   output cache_sys_pkg::line_t       store_wr_line,
   output cache_sys_pkg::line_strb_t  store_wr_mask,
   output logic [tag_w-1:0]           store_wr_tag,
   output logic                       store_wr_valid
);

   localparam logic [1:0] st_idle     = 2'd0;
   localparam logic [1:0] st_lookup   = 2'd1;
   localparam logic [1:0] st_mem_wait = 2'd2;
   localparam logic [1:0] st_refill   = 2'd3;

   logic [1:0] state_q;
   logic       hit_q;

   logic [cache_sys_pkg::word_offset_w-1:0] offset;
   logic [tag_w-1:0]                        tag;
   logic                                    is_write;
   logic                                    hit;
   cache_sys_pkg::line_t                    wr_line;
   cache_sys_pkg::line_strb_t               line_strb;

   // address split, requester holds cpu_req until ack
   assign offset      = cpu_req.addr[cache_sys_pkg::word_offset_w-1:0];
   assign store_index = cpu_req.addr[cache_sys_pkg::word_offset_w +: NLINES_W];
   assign tag         = cpu_req.addr[cache_sys_pkg::addr_w-1 -: tag_w];
   assign is_write    = |cpu_req.wstrb;

   assign hit = rd_valid && (rd_tag == tag);

   // write word copied to every slot, strobes pick the right one
   assign wr_line.flat = {cache_sys_pkg::nwords{cpu_req.wdata}};
   assign line_strb    = cache_sys_pkg::line_strb_t'(cpu_req.wstrb)
                         << (offset * (cache_sys_pkg::data_w / 8));

   assign mem_req.addr  = cpu_req.addr[cache_sys_pkg::addr_w-1:cache_sys_pkg::word_offset_w];
   assign mem_req.wdata = wr_line;
   assign mem_req.wstrb = line_strb;

   assign store_wr_tag   = tag;
   assign store_wr_valid = 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= st_idle;
         mem_valid <= 1'b0;
         hit_q     <= 1'b0;
      end else begin
         // one-cycle request pulse to the RAM
         mem_valid <= 1'b0;
         case (state_q)
            st_idle: begin
               if (req) begin
                  state_q <= st_lookup;
               end
            end
            st_lookup: begin
               hit_q <= hit;
               if (hit && !is_write) begin
                  state_q <= st_idle;
               end else begin
                  mem_valid <= 1'b1;
                  state_q   <= st_mem_wait;
               end
            end
            st_mem_wait: begin
               if (mem_ack) begin
                  state_q <= is_write ? st_idle : st_refill;
               end
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   always_comb begin
      store_rd_en   = (state_q == st_idle) && req;
      ack           = 1'b0;
      rdata         = rd_line.words[offset];
      store_wr_en   = 1'b0;
      store_wr_line = wr_line;
      store_wr_mask = line_strb;
      case (state_q)
         st_lookup: begin
            ack = hit && !is_write;
         end
         st_mem_wait: begin
            // write-through done, merge only if the line was present
            if (mem_ack && is_write) begin
               ack         = 1'b1;
               store_wr_en = hit_q;
            end
         end
         st_refill: begin
            // RAM output holds the fetched line until its next access
            ack           = 1'b1;
            rdata         = mem_rdata.words[offset];
            store_wr_en   = 1'b1;
            store_wr_line = mem_rdata;
            store_wr_mask = '1;
         end
         default: begin
            ack = 1'b0;
         end
      endcase
   end

endmodule

// File: cache_store.sv
`timescale 1ns/1ps

module cache_store #(
   parameter int NLINES_W = 4,
   localparam int tag_w = cache_sys_pkg::addr_w - cache_sys_pkg::word_offset_w - NLINES_W
) (
   input  logic                       clk,
   input  logic                       rst_n,

   input  logic [NLINES_W-1:0]        store_index,
   input  logic                       store_rd_en,
   output logic [tag_w-1:0]           rd_tag,
   output logic                       rd_valid,
   output cache_sys_pkg::line_t       rd_line,

   input  logic                       store_wr_en,
   input  cache_sys_pkg::line_t       store_wr_line,
   input  cache_sys_pkg::line_strb_t  store_wr_mask,
   input  logic [tag_w-1:0]           store_wr_tag,
   input  logic                       store_wr_valid
);

   localparam int nlines = 2 ** NLINES_W;

   logic [nlines-1:0]    valid_q;
   logic [tag_w-1:0]     tag_mem [nlines];
   cache_sys_pkg::line_t data_mem [nlines];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q  <= '0;
         rd_valid <= 1'b0;
      end else begin
         if (store_wr_en) begin
            valid_q[store_index] <= store_wr_valid;
         end
         if (store_rd_en) begin
            rd_valid <= valid_q[store_index];
         end
      end
   end

   // tag and data arrays
   always_ff @(posedge clk) begin
      if (store_wr_en) begin
         tag_mem[store_index] <= store_wr_tag;
         for (int b = 0; b < cache_sys_pkg::line_w / 8; b++) begin
            if (store_wr_mask[b]) begin
               data_mem[store_index].flat[8*b +: 8] <= store_wr_line.flat[8*b +: 8];
            end
         end
      end
      if (store_rd_en) begin
         rd_tag  <= tag_mem[store_index];
         rd_line <= data_mem[store_index];
      end
   end

endmodule

// File: cache_sys.f
cache_sys_pkg.sv
ram_sp_be.sv
cache_store.sv
cache_ctrl.sv
cache_sys_top.sv
cache_sys_properties.sv
cache_sys_tb.sv

// File: cache_sys_pkg.sv
package cache_sys_pkg;

   // front-end word addressing
   localparam int addr_w = 12;
   localparam int data_w = 32;

   // four words per line
   localparam int word_offset_w = 2;
   localparam int nwords = 2 ** word_offset_w;
   localparam int line_w = nwords * data_w;

   // back-end addresses whole lines
   localparam int be_addr_w = addr_w - word_offset_w;

   typedef logic [data_w-1:0] word_t;
   typedef logic [data_w/8-1:0] wstrb_t;
   typedef logic [line_w/8-1:0] line_strb_t;

   // flat for the RAM port, words for word select
   typedef union packed {
      logic [line_w-1:0]      flat;
      word_t [nwords-1:0]     words;
   } line_t;

   // no strobe set means read
   typedef struct packed {
      logic [addr_w-1:0] addr;
      word_t             wdata;
      wstrb_t            wstrb;
   } cpu_req_t;

   // no strobe set means line read
   typedef struct packed {
      logic [be_addr_w-1:0] addr;
      line_t                wdata;
      line_strb_t           wstrb;
   } mem_req_t;

endpackage

// File: cache_sys_properties.sv
`timescale 1ns/1ps

module cache_sys_properties (
   input logic clk,
   input logic rst_n,
   input logic req,
   input logic ack,
   input logic mem_valid,
   input logic mem_ack
);

   int unsigned violations = 0;

   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) ack |-> req)
      else begin
         violations++;
         $error("ack raised without req");
      end

   // ack is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
      else begin
         violations++;
         $error("ack high for two cycles");
      end

   mem_ack_follows_valid: assert property (@(posedge clk) disable iff (!rst_n)
                                           mem_ack |-> $past(mem_valid))
      else begin
         violations++;
         $error("mem_ack without mem_valid in the previous cycle");
      end

   mem_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                     mem_valid |=> !mem_valid)
      else begin
         violations++;
         $error("mem_valid high for two cycles");
      end

endmodule

bind cache_ctrl cache_sys_properties props_i (
   .clk      (clk),
   .rst_n    (rst_n),
   .req      (req),
   .ack      (ack),
   .mem_valid(mem_valid),
   .mem_ack  (mem_ack)
);

// File: cache_sys_tb.sv
`timescale 1ns/1ps

module cache_sys_tb;

   localparam int win_words = 64;
   localparam int ack_timeout = 50;
   localparam int random_ops = 400;

   logic                    clk;
   logic                    rst_n;
   logic                    req;
   cache_sys_pkg::cpu_req_t cpu_req;
   cache_sys_pkg::word_t    rdata;
   logic                    ack;

   // expected memory contents for the address window
   cache_sys_pkg::word_t model [win_words];
   logic [31:0]          lfsr;

   cache_sys_top #(
      .NLINES_W(4)
   ) dut_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .cpu_req(cpu_req),
      .rdata  (rdata),
      .ack    (ack)
   );

   always #10 clk = ~clk;

   function automatic logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], next_bit()};
      end
      return r;
   endfunction

   // four tags over four line indexes, so lines collide
   function automatic logic [cache_sys_pkg::addr_w-1:0] win_addr(logic [5:0] idx);
      logic [cache_sys_pkg::addr_w-1:0] a;
      a = '0;
      a[3:0] = idx[3:0];
      a[7:6] = idx[5:4];
      return a;
   endfunction

   task automatic stop_on_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(string test, cache_sys_pkg::word_t exp, cache_sys_pkg::word_t act);
      if (act !== exp) begin
         $display("FAILED %s: expected %h, actual %h", test, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic check_ack(string test, logic exp, logic act);
      if (act !== exp) begin
         $display("FAILED %s: expected ack %b, actual ack %b", test, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic wait_ack(string test);
      int n;
      n = 0;
      @(negedge clk);
      while (ack !== 1'b1) begin
         n++;
         if (n >= ack_timeout) begin
            $display("%s: no ack within %0d cycles", test, ack_timeout);
            stop_on_failure();
         end
         @(negedge clk);
      end
   endtask

   task automatic access(string test, logic [5:0] idx, cache_sys_pkg::word_t wdata,
                         cache_sys_pkg::wstrb_t wstrb, output cache_sys_pkg::word_t rd);
      @(posedge clk);
      req     <= 1'b1;
      cpu_req <= '{addr: win_addr(idx), wdata: wdata, wstrb: wstrb};
      wait_ack(test);
      rd = rdata;
      @(posedge clk);
      req <= 1'b0;
   endtask

   task automatic write_word(string test, logic [5:0] idx, cache_sys_pkg::word_t wdata,
                             cache_sys_pkg::wstrb_t wstrb);
      cache_sys_pkg::word_t unused;
      access(test, idx, wdata, wstrb, unused);
      for (int b = 0; b < cache_sys_pkg::data_w / 8; b++) begin
         if (wstrb[b]) begin
            model[idx][8*b +: 8] = wdata[8*b +: 8];
         end
      end
   endtask

   task automatic read_check(string test, logic [5:0] idx);
      cache_sys_pkg::word_t rd;
      access(test, idx, '0, '0, rd);
      check_word(test, model[idx], rd);
   endtask

   // line already present, so ack comes one cycle after req is seen
   task automatic read_hit_timed(string test, logic [5:0] idx);
      @(posedge clk);
      req     <= 1'b1;
      cpu_req <= '{addr: win_addr(idx), wdata: '0, wstrb: '0};
      @(negedge clk);
      check_ack({test, " request cycle"}, 1'b0, ack);
      @(negedge clk);
      check_ack({test, " hit cycle"}, 1'b1, ack);
      check_word(test, model[idx], rdata);
      @(posedge clk);
      req <= 1'b0;
   endtask

   initial begin
      cache_sys_pkg::wstrb_t st;
      logic [5:0]            idx;
      clk     = 1'b0;
      rst_n   = 1'b0;
      req     = 1'b0;
      cpu_req = '0;
      lfsr    = 32'd68;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      repeat (5) begin
         @(negedge clk);
         check_ack("idle after reset", 1'b0, ack);
      end

      // RAM starts undefined
      for (int i = 0; i < win_words; i++) begin
         write_word("window fill", 6'(i), rand_bits(32), 4'hf);
      end
      for (int i = 0; i < win_words; i++) begin
         read_check("window read", 6'(i));
      end

      read_check("repeat read first", 6'd9);
      read_hit_timed("repeat read second", 6'd9);

      read_check("write hit prime", 6'd22);
      write_word("write hit", 6'd22, rand_bits(32), 4'b0101);
      read_hit_timed("write hit readback", 6'd22);

      // same index, tags 0 and 3
      for (int k = 0; k < 4; k++) begin
         read_check("conflict low tag", 6'd5);
         read_check("conflict high tag", 6'd53);
      end

      for (int n = 0; n < random_ops; n++) begin
         idx = 6'(rand_bits(6));
         if (next_bit()) begin
            st = 4'(rand_bits(4));
            if (st == '0) begin
               st = 4'b1000;
            end
            write_word("random write", idx, rand_bits(32), st);
         end else begin
            read_check("random read", idx);
         end
      end

      if (dut_i.ctrl_i.props_i.violations != 0) begin
         $display("controller assertions failed %0d times", dut_i.ctrl_i.props_i.violations);
         stop_on_failure();
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: cache_sys_top.sv
`timescale 1ns/1ps

module cache_sys_top #(
   parameter int NLINES_W = 4
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req,
   input  cache_sys_pkg::cpu_req_t  cpu_req,
   output cache_sys_pkg::word_t     rdata,
   output logic                     ack
);

   localparam int tag_w = cache_sys_pkg::addr_w - cache_sys_pkg::word_offset_w - NLINES_W;

   logic                      mem_valid;
   logic                      mem_ack;
   cache_sys_pkg::mem_req_t   mem_req;
   cache_sys_pkg::line_t      mem_rdata;

   logic [NLINES_W-1:0]       store_index;
   logic                      store_rd_en;
   logic [tag_w-1:0]          rd_tag;
   logic                      rd_valid;
   cache_sys_pkg::line_t      rd_line;
   logic                      store_wr_en;
   cache_sys_pkg::line_t      store_wr_line;
   cache_sys_pkg::line_strb_t store_wr_mask;
   logic [tag_w-1:0]          store_wr_tag;
   logic                      store_wr_valid;

   cache_ctrl #(
      .NLINES_W(NLINES_W)
   ) ctrl_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .cpu_req       (cpu_req),
      .rdata         (rdata),
      .ack           (ack),
      .mem_valid     (mem_valid),
      .mem_req       (mem_req),
      .mem_rdata     (mem_rdata),
      .mem_ack       (mem_ack),
      .store_index   (store_index),
      .store_rd_en   (store_rd_en),
      .rd_tag        (rd_tag),
      .rd_valid      (rd_valid),
      .rd_line       (rd_line),
      .store_wr_en   (store_wr_en),
      .store_wr_line (store_wr_line),
      .store_wr_mask (store_wr_mask),
      .store_wr_tag  (store_wr_tag),
      .store_wr_valid(store_wr_valid)
   );

   cache_store #(
      .NLINES_W(NLINES_W)
   ) store_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .store_index   (store_index),
      .store_rd_en   (store_rd_en),
      .rd_tag        (rd_tag),
      .rd_valid      (rd_valid),
      .rd_line       (rd_line),
      .store_wr_en   (store_wr_en),
      .store_wr_line (store_wr_line),
      .store_wr_mask (store_wr_mask),
      .store_wr_tag  (store_wr_tag),
      .store_wr_valid(store_wr_valid)
   );

   ram_sp_be ram_i (
      .clk  (clk),
      .en   (mem_valid),
      .addr (mem_req.addr),
      .wstrb(mem_req.wstrb),
      .din  (mem_req.wdata),
      .dout (mem_rdata)
   );

   // RAM answers one cycle after the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_ack <= 1'b0;
      end else begin
         mem_ack <= mem_valid;
      end
   end

endmodule

// File: ram_sp_be.sv
`timescale 1ns/1ps

module ram_sp_be (
   input  logic                              clk,
   input  logic                              en,
   input  logic [cache_sys_pkg::be_addr_w-1:0] addr,
   input  cache_sys_pkg::line_strb_t         wstrb,
   input  cache_sys_pkg::line_t              din,
   output cache_sys_pkg::line_t              dout
);

   cache_sys_pkg::line_t mem [2 ** cache_sys_pkg::be_addr_w];

   // dout only changes on an access
   always_ff @(posedge clk) begin
      if (en) begin
         for (int b = 0; b < cache_sys_pkg::line_w / 8; b++) begin
            if (wstrb[b]) begin
               mem[addr].flat[8*b +: 8] <= din.flat[8*b +: 8];
            end
         end
         dout <= mem[addr];
      end
   end

endmodule
